//--- tinyCpu.f
+incdir+hw
hw/cpuPkg.sv
hw/isaPkg.sv
hw/instructionFetch.sv
hw/stateMachine.sv
hw/executeUnit.sv
hw/tinyCpu.sv
test/tinyCpu_properties.sv
test/tinyCpu_tb.sv

//--- run.sh
#!/bin/sh
# builds the tinyCpu testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tinyCpu_tb \
    -f tinyCpu.f -o tinyCpu_sim

simOutput=$(./obj_dir/tinyCpu_sim 2>&1) || true
echo "$simOutput"
echo "$simOutput" | grep -q "Simulation finished: PASS"

//--- test/tinyCpu_tb.sv
`timescale 1ns/1ps

`include "tinyCpu_defines.svh"

module tinyCpu_tb;

    import cpuPkg::*;

    localparam int numRows       = 5;
    localparam int maxOutputs    = 6;
    localparam int resetCycles   = 2;
    localparam int haltWatch     = 50;
    localparam int maxPauseTotal = 64; // pause cycles allowed in one row.

    // opcode field values of the instruction set.
    localparam logic [`OPCODE_WIDTH-1:0] opNop = 6'd0;
    localparam logic [`OPCODE_WIDTH-1:0] opLda = 6'd1;
    localparam logic [`OPCODE_WIDTH-1:0] opAdd = 6'd2;
    localparam logic [`OPCODE_WIDTH-1:0] opSub = 6'd3;
    localparam logic [`OPCODE_WIDTH-1:0] opAnd = 6'd4;
    localparam logic [`OPCODE_WIDTH-1:0] opXor = 6'd5;
    localparam logic [`OPCODE_WIDTH-1:0] opSta = 6'd6;
    localparam logic [`OPCODE_WIDTH-1:0] opLdi = 6'd7;
    localparam logic [`OPCODE_WIDTH-1:0] opOut = 6'd8;
    localparam logic [`OPCODE_WIDTH-1:0] opJnz = 6'd9;
    localparam logic [`OPCODE_WIDTH-1:0] opHlt = 6'd10;

    logic       clk;
    logic       nrst;
    logic       run;
    logic       progWrite;
    progAddr_t  progAddr;
    instrWord_t progData;
    data_t      outData;
    logic       outValid;
    logic       halted;

    // stimulus table, one entry per row.
    instrWord_t progTable [numRows][`PROG_DEPTH];
    data_t      expOut    [numRows][maxOutputs];
    int         expCount  [numRows];
    int         execCount [numRows]; // words latched, reset NOP and HLT included.
    bit         pauseFlag [numRows];
    bit         loadFlag  [numRows]; // clear means restart from the program left in memory.

    data_t  seenValues[$];
    int     errors;
    int     checks;
    int     cycleCount;
    int     cycleLimit;
    integer seed;

    tinyCpu dut_i (
        .clk       (clk),
        .nrst      (nrst),
        .run       (run),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .outData   (outData),
        .outValid  (outValid),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fillTable();
        instrWord_t haltProg [`PROG_DEPTH];
        instrWord_t dataProg [`PROG_DEPTH];
        instrWord_t loopProg [`PROG_DEPTH];
        data_t      noneOut  [maxOutputs];
        data_t      dataOut  [maxOutputs];
        data_t      loopOut  [maxOutputs];
        haltProg = '{0: {opNop, 4'd0}, default: {opHlt, 4'd0}};
        // r1 = 9, 12 + 9, 3 - 21 wraps, 238 & 9, 8 ^ 21, reload r1.
        dataProg = '{{opLdi, 4'd9}, {opSta, 4'd1}, {opLdi, 4'd12}, {opAdd, 4'd1},
                     {opOut, 4'd0}, {opSta, 4'd2}, {opLdi, 4'd3},  {opSub, 4'd2},
                     {opOut, 4'd0}, {opAnd, 4'd1}, {opOut, 4'd0},  {opXor, 4'd2},
                     {opOut, 4'd0}, {opLda, 4'd1}, {opOut, 4'd0},  {opHlt, 4'd0}};
        // countdown from 5, r1 holds the decrement.
        loopProg = '{0: {opLdi, 4'd1}, 1: {opSta, 4'd1}, 2: {opLdi, 4'd5},
                     3: {opOut, 4'd0}, 4: {opSub, 4'd1}, 5: {opJnz, 4'd3},
                     default: {opHlt, 4'd0}};
        noneOut = '{default: 8'd0};
        dataOut = '{8'd21, 8'd238, 8'd8, 8'd29, 8'd9, 8'd0};
        loopOut = '{8'd5, 8'd4, 8'd3, 8'd2, 8'd1, 8'd0};

        progTable[0] = haltProg;
        progTable[1] = dataProg;
        progTable[2] = loopProg;
        progTable[3] = dataProg;
        progTable[4] = dataProg; // not loaded, row 3 left it in memory.
        expOut[0] = noneOut;
        expOut[1] = dataOut;
        expOut[2] = loopOut;
        expOut[3] = dataOut;
        expOut[4] = dataOut;
        expCount  = '{0, 5, 5, 5, 5};
        execCount = '{3, 17, 20, 17, 17};
        pauseFlag = '{0, 0, 0, 1, 0};
        loadFlag  = '{1, 1, 1, 1, 0};
    endtask

    function automatic int computeCycleLimit();
        int total;
        total = 0;
        for (int r = 0; r < numRows; r++) begin
            total += 4 * (execCount[r] + 8);
            total += resetCycles + 1 + haltWatch;
            if (loadFlag[r]) begin
                total += `PROG_DEPTH;
            end
            if (pauseFlag[r]) begin
                total += maxPauseTotal;
            end
        end
        return total;
    endfunction

    task automatic checkValue(input string what, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic applyReset(input int row);
        nrst = 1'b0;
        run  = 1'b0;
        repeat (resetCycles) begin
            @(negedge clk);
            checkValue($sformatf("row %0d outValid in reset", row), int'(outValid), 0);
            checkValue($sformatf("row %0d halted in reset", row), int'(halted), 0);
        end
        nrst = 1'b1;
        @(negedge clk);
        checkValue($sformatf("row %0d outValid after reset", row), int'(outValid), 0);
        checkValue($sformatf("row %0d halted after reset", row), int'(halted), 0);
    endtask

    task automatic loadProgram(input int row);
        for (int i = 0; i < `PROG_DEPTH; i++) begin
            progWrite = 1'b1;
            progAddr  = progAddr_t'(i);
            progData  = progTable[row][i];
            @(negedge clk);
        end
        progWrite = 1'b0;
    endtask

    // runs until halted, optionally dropping run for short random spans.
    task automatic collectOutputs(input int row, input bit usePause);
        int pauseLeft;
        int budget;
        bit done;
        pauseLeft = 0;
        budget    = maxPauseTotal;
        done      = 1'b0;
        seenValues.delete();
        run = 1'b1;
        while (!done) begin
            @(negedge clk);
            // samples belong to the run level of the cycle just ended.
            if (outValid) begin
                seenValues.push_back(outData);
            end
            if (!run) begin
                checkValue($sformatf("row %0d outValid while paused", row), int'(outValid), 0);
            end
            if (halted) begin
                done = 1'b1;
            end else if (pauseLeft > 0) begin
                pauseLeft--;
                if (pauseLeft == 0) begin
                    run = 1'b1;
                end
            end else if (usePause && (budget > 0) && ($unsigned($random(seed)) % 6 == 0)) begin
                pauseLeft = 1 + $unsigned($random(seed)) % 8;
                if (pauseLeft > budget) begin
                    pauseLeft = budget;
                end
                budget -= pauseLeft;
                run = 1'b0;
            end
        end
        run = 1'b1;
    endtask

    task automatic checkOutputs(input int row);
        checkValue($sformatf("row %0d output count", row), seenValues.size(), expCount[row]);
        for (int i = 0; (i < expCount[row]) && (i < seenValues.size()); i++) begin
            checkValue($sformatf("row %0d output %0d", row, i),
                       int'(seenValues[i]), int'(expOut[row][i]));
        end
    endtask

    // a halted machine keeps halted up and emits nothing more.
    task automatic watchHalted(input int row);
        repeat (haltWatch) begin
            @(negedge clk);
            checkValue($sformatf("row %0d halted after HLT", row), int'(halted), 1);
            checkValue($sformatf("row %0d outValid after HLT", row), int'(outValid), 0);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            errors++;
            $display("The run timed out after %0d cycles before all rows finished", cycleCount);
            $display("%0d errors in %0d checks", errors, checks);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        nrst      = 1'b0;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        errors    = 0;
        checks    = 0;
        seed      = 91137;
        fillTable();
        cycleLimit = computeCycleLimit();

        for (int row = 0; row < numRows; row++) begin
            applyReset(row);
            if (loadFlag[row]) begin
                loadProgram(row);
            end
            collectOutputs(row, pauseFlag[row]);
            checkOutputs(row);
            watchHalted(row);
        end
        run = 1'b0;
        errors += dut_i.sm_i.props_i.failCount; // state machine assertion failures.

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- test/tinyCpu_properties.sv
`timescale 1ns/1ps

module tinyCpu_properties (
    input logic                clk,
    input logic                nrst,
    input logic                endAddressing,
    input logic                getInstruction,
    input logic                enableFFs,
    input isaPkg::cycleMode_t  mode,
    input isaPkg::tState_t     timeState,
    input isaPkg::opcode_t     currentInstruction
);

    import isaPkg::*;

    int failCount = 0; // failed assertions, read by the testbench.

    // the generator only counts T0 to T6.
    property legalTimeState;
        @(posedge clk) disable iff (!nrst) timeState <= T6;
    endproperty

    // a phase end and an instruction fetch never share a cycle.
    property exclusivePhaseEnds;
        @(posedge clk) disable iff (!nrst) !(endAddressing && getInstruction);
    endproperty

    // a cycle with enableFFs low leaves the sequencing state untouched.
    property frozenWhenDisabled;
        @(posedge clk) disable iff (!nrst)
            !enableFFs |=> $stable(mode) && $stable(timeState) && $stable(currentInstruction);
    endproperty

    timeStateCheck: assert property (legalTimeState)
        else begin
            failCount++;
            $error("time state reached the unused code");
        end
    phaseEndCheck: assert property (exclusivePhaseEnds)
        else begin
            failCount++;
            $error("endAddressing and getInstruction high in the same cycle");
        end
    freezeCheck: assert property (frozenWhenDisabled)
        else begin
            failCount++;
            $error("sequencing state changed while enableFFs was low");
        end

endmodule

bind stateMachine tinyCpu_properties props_i (
    .clk                (clk),
    .nrst               (nrst),
    .endAddressing      (endAddressing),
    .getInstruction     (getInstruction),
    .enableFFs          (enableFFs),
    .mode               (mode),
    .timeState          (timeState),
    .currentInstruction (currentInstruction)
);

//--- hw/tinyCpu.sv
`timescale 1ns/1ps

module tinyCpu (
    input  logic                clk,
    input  logic                nrst,
    input  logic                run,
    input  logic                progWrite,
    input  cpuPkg::progAddr_t   progAddr,
    input  cpuPkg::instrWord_t  progData,
    output cpuPkg::data_t       outData,
    output logic                outValid,
    output logic                halted
);

    import cpuPkg::*;
    import isaPkg::*;

    opcode_t    decodedInstruction;
    regAddr_t   decodedAddress;
    opcode_t    currentInstruction;
    regAddr_t   currentAddress;
    tState_t    timeState;
    cycleMode_t mode;
    logic       noAddressing;
    logic       endAddressing;
    logic       getInstruction;
    logic       pcLoad;

    instructionFetch fetch_i (
        .clk                (clk),
        .nrst               (nrst),
        .run                (run),
        .progWrite          (progWrite),
        .progAddr           (progAddr),
        .progData           (progData),
        .getInstruction     (getInstruction),
        .pcLoad             (pcLoad),
        .jumpTarget         (currentAddress), // JNZ target is its own operand.
        .decodedInstruction (decodedInstruction),
        .decodedAddress     (decodedAddress)
    );

    stateMachine sm_i (
        .clk                (clk),
        .nrst               (nrst),
        .noAddressing       (noAddressing),
        .getInstruction     (getInstruction),
        .endAddressing      (endAddressing),
        .decodedInstruction (decodedInstruction),
        .decodedAddress     (decodedAddress),
        .enableFFs          (run),
        .currentInstruction (currentInstruction),
        .currentAddress     (currentAddress),
        .timeState          (timeState),
        .mode               (mode)
    );

    executeUnit exec_i (
        .clk                (clk),
        .nrst               (nrst),
        .run                (run),
        .currentInstruction (currentInstruction),
        .currentAddress     (currentAddress),
        .timeState          (timeState),
        .mode               (mode),
        .noAddressing       (noAddressing),
        .endAddressing      (endAddressing),
        .getInstruction     (getInstruction),
        .pcLoad             (pcLoad),
        .outData            (outData),
        .outValid           (outValid),
        .halted             (halted)
    );

endmodule

//--- hw/executeUnit.sv
`timescale 1ns/1ps

`include "tinyCpu_defines.svh"

module executeUnit (
    input  logic                clk,
    input  logic                nrst,
    input  logic                run,
    input  isaPkg::opcode_t     currentInstruction,
    input  cpuPkg::regAddr_t    currentAddress,
    input  isaPkg::tState_t     timeState,
    input  isaPkg::cycleMode_t  mode,
    output logic                noAddressing,
    output logic                endAddressing,
    output logic                getInstruction,
    output logic                pcLoad,
    output cpuPkg::data_t       outData,
    output logic                outValid,
    output logic                halted
);

    import cpuPkg::*;
    import isaPkg::*;

    data_t regFile [2**`ADDR_WIDTH];
    data_t readData;
    data_t operand;
    data_t acc;
    data_t aluResult;
    data_t outReg;
    logic  validReg;
    logic  isOperandOp;
    logic  lastSlot;
    logic  execSlot;

    // opcodes that need a register read before they execute.
    always_comb begin
        case (currentInstruction)
            LDA, ADD, SUB, AND, XOR: isOperandOp = 1'b1;
            default:                 isOperandOp = 1'b0;
        endcase
    end

    // time state on which the instruction phase ends.
    always_comb begin
        case (currentInstruction)
            ADD, SUB, AND, XOR, JNZ: lastSlot = (timeState == T1);
            HLT:                     lastSlot = 1'b0; // spins until reset.
            default:                 lastSlot = (timeState == T0);
        endcase
    end

    // every instruction does its work in the first instruction state.
    assign execSlot = run && (mode == INSTRUCTION) && (timeState == T0);

    assign noAddressing   = ~isOperandOp;
    assign endAddressing  = run && (mode == ADDRESS) && isOperandOp && (timeState == T1);
    assign getInstruction = run && (mode == INSTRUCTION) && lastSlot;
    assign pcLoad         = execSlot && (currentInstruction == JNZ) && (acc != '0);

    // operand fetch, read at T0 and handed over at T1.
    always_ff @(posedge clk) begin
        if (run && (mode == ADDRESS)) begin
            if (timeState == T0) begin
                readData <= regFile[currentAddress];
            end
            if (timeState == T1) begin
                operand <= readData;
            end
        end
    end

    always_comb begin : alu
        case (currentInstruction)
            ADD:     aluResult = acc + operand; // modulo 256.
            SUB:     aluResult = acc - operand;
            AND:     aluResult = acc & operand;
            XOR:     aluResult = acc ^ operand;
            default: aluResult = operand; // LDA just passes it on.
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            acc <= '0;
        end else if (execSlot) begin
            if (isOperandOp) begin
                acc <= aluResult;
            end else if (currentInstruction == LDI) begin
                acc <= {{(`DATA_WIDTH-`ADDR_WIDTH){1'b0}}, currentAddress};
            end
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < 2**`ADDR_WIDTH; i++) begin
                regFile[i] <= '0;
            end
        end else if (execSlot && (currentInstruction == STA)) begin
            regFile[currentAddress] <= acc;
        end
    end

    // output register, the strobe lasts one running cycle.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            outReg   <= '0;
            validReg <= 1'b0;
        end else if (run) begin
            validReg <= execSlot && (currentInstruction == OUT);
            if (execSlot && (currentInstruction == OUT)) begin
                outReg <= acc;
            end
        end
    end

    assign outData  = outReg;
    assign outValid = validReg && run; // a strobe caught by a pause shows after it.
    assign halted   = (mode == INSTRUCTION) && (currentInstruction == HLT);

endmodule

//--- hw/stateMachine.sv
`timescale 1ns/1ps

module stateMachine (
    input  logic                clk,
    input  logic                nrst,
    input  logic                noAddressing,
    input  logic                getInstruction,
    input  logic                endAddressing,
    input  isaPkg::opcode_t     decodedInstruction,
    input  cpuPkg::regAddr_t    decodedAddress,
    input  logic                enableFFs,
    output isaPkg::opcode_t     currentInstruction,
    output cpuPkg::regAddr_t    currentAddress,
    output isaPkg::tState_t     timeState,
    output isaPkg::cycleMode_t  mode
);

    import cpuPkg::*;
    import isaPkg::*;

    cycleMode_t nextMode;
    tState_t    nextTime;
    opcode_t    nextInstruction;
    regAddr_t   nextAddress;

    always_comb begin : timingGeneration
        nextMode = mode;

        // free running count, T6 wraps back to T0.
        case (timeState)
            T0:      nextTime = T1;
            T1:      nextTime = T2;
            T2:      nextTime = T3;
            T3:      nextTime = T4;
            T4:      nextTime = T5;
            T5:      nextTime = T6;
            default: nextTime = T0;
        endcase

        if (endAddressing) begin
            nextMode = INSTRUCTION; // operand is in, start executing.
            nextTime = T0;
        end else if (getInstruction) begin
            nextMode = ADDRESS; // next word gets latched this edge.
            nextTime = T0;
        end else if ((mode == ADDRESS) && noAddressing) begin
            // nothing to fetch, skip straight to execution.
            nextMode = INSTRUCTION;
            nextTime = T0;
        end

        if (!enableFFs) begin
            nextMode = mode;
            nextTime = timeState;
        end
    end

    always_comb begin : instructionLatch
        nextInstruction = currentInstruction;
        nextAddress     = currentAddress;
        if (getInstruction && enableFFs) begin
            nextInstruction = decodedInstruction;
            nextAddress     = decodedAddress;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            mode      <= ADDRESS;
            timeState <= T0;
        end else begin
            mode      <= nextMode;
            timeState <= nextTime;
        end
    end

    // reset leaves a NOP in place, so the first real word comes two cycles later.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            currentInstruction <= NOP;
            currentAddress     <= '0;
        end else begin
            currentInstruction <= nextInstruction;
            currentAddress     <= nextAddress;
        end
    end

endmodule

//--- hw/instructionFetch.sv
`timescale 1ns/1ps

`include "tinyCpu_defines.svh"

module instructionFetch (
    input  logic                clk,
    input  logic                nrst,
    input  logic                run,
    input  logic                progWrite,
    input  cpuPkg::progAddr_t   progAddr,
    input  cpuPkg::instrWord_t  progData,
    input  logic                getInstruction,
    input  logic                pcLoad,
    input  cpuPkg::regAddr_t    jumpTarget,
    output isaPkg::opcode_t     decodedInstruction,
    output cpuPkg::regAddr_t    decodedAddress
);

    import cpuPkg::*;
    import isaPkg::*;

    instrWord_t progMem [`PROG_DEPTH];
    progAddr_t  pc;
    instrWord_t fetchedWord;
    logic [`OPCODE_WIDTH-1:0] opField;

    // program memory, loaded from the outside port at any time.
    always_ff @(posedge clk) begin
        if (progWrite) begin
            progMem[progAddr] <= progData;
        end
    end

    // program counter.
    // a jump request and an instruction fetch never fall in the same cycle.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            pc <= '0;
        end else if (run) begin
            if (pcLoad) begin
                pc <= jumpTarget; // JNZ taken.
            end else if (getInstruction) begin
                pc <= progAddr_t'(pc + 1'b1); // wraps after the last word.
            end
        end
    end

    assign fetchedWord = progMem[pc];
    assign opField     = fetchedWord[`INSTR_WIDTH-1 -: `OPCODE_WIDTH];

    // decoder runs continuously on the word at the program counter.
    always_comb begin : decodeWord
        if (opField <= HLT) begin
            decodedInstruction = opcode_t'(opField);
        end else begin
            decodedInstruction = NOP; // unknown codes do nothing.
        end
        decodedAddress = fetchedWord[`ADDR_WIDTH-1:0];
    end

endmodule

//--- hw/isaPkg.sv
`include "tinyCpu_defines.svh"

package isaPkg;

    // codes above HLT are turned into NOP by the decoder.
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        NOP = 0,
        LDA = 1,  // acc <- reg.
        ADD = 2,
        SUB = 3,
        AND = 4,
        XOR = 5,
        STA = 6,  // reg <- acc.
        LDI = 7,  // acc <- immediate address field.
        OUT = 8,
        JNZ = 9,
        HLT = 10
    } opcode_t;

    // which half of the instruction cycle is running.
    typedef enum logic {
        ADDRESS,
        INSTRUCTION
    } cycleMode_t;

    // time states, the eighth code is never used.
    typedef enum logic [2:0] {
        T0,
        T1,
        T2,
        T3,
        T4,
        T5,
        T6
    } tState_t;

endpackage

//--- hw/cpuPkg.sv
`include "tinyCpu_defines.svh"

package cpuPkg;

    // accumulator, register contents and output value.
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // operand field of an instruction, selects a register.
    typedef logic [`ADDR_WIDTH-1:0] regAddr_t;

    // program counter and load port address.
    typedef logic [`PC_WIDTH-1:0] progAddr_t;

    // one program word as stored in program memory.
    typedef logic [`INSTR_WIDTH-1:0] instrWord_t;

endpackage

//--- hw/tinyCpu_defines.svh
`ifndef TINYCPU_DEFINES_SVH
`define TINYCPU_DEFINES_SVH

// accumulator, register file and output width.
`define DATA_WIDTH 8

// opcode field in the upper bits of a program word.
`define OPCODE_WIDTH 6

// operand field, also the register file address.
`define ADDR_WIDTH 4

// program memory depth and the program counter that walks it.
`define PROG_DEPTH 16
`define PC_WIDTH 4

// full program word, opcode then address.
`define INSTR_WIDTH 10

`endif
